/* sprite_pkg.sv */
// Sprite printer shared types
package sprite_pkg;

	////////////////////////////////////////
	// widths that carry a meaning.
	////////////////////////////////////////

	typedef logic [9:0]  coord_t;         // screen x or y coordinate.
	typedef logic [13:0] mem_addr_t;      // sprite memory address.
	typedef logic [2:0]  sprite_index_t;  // register bank index, eight entries.
	typedef logic [4:0]  sprite_offset_t; // pixel offset inside one sprite.

	// every sprite is a square of this many pixels on a side.
	localparam int SPRITE_SIZE = 20;

	// the last word of sprite memory holds the background color.
	localparam mem_addr_t BG_ADDR = 14'd16383;

	////////////////////////////////////////
	// register bank entry and lookup result.
	////////////////////////////////////////

	// one sprite register, 35 bits in all.
	typedef struct packed {
		logic      active; // entry takes part in the hit search.
		coord_t    pos_x;  // left column of the sprite on screen.
		coord_t    pos_y;  // top line of the sprite on screen.
		mem_addr_t base;   // address of the top-left pixel.
	} sprite_entry_t;

	// result of one coordinate search.
	// row and col are only meaningful when hit is set.
	typedef struct packed {
		logic           hit;
		mem_addr_t      base;
		sprite_offset_t row; // line offset from the sprite top.
		sprite_offset_t col; // column offset from the sprite left edge.
	} lookup_t;

	////////////////////////////////////////
	// print FSM states.
	////////////////////////////////////////

	typedef enum logic [2:0] {
		st_idle,   // waiting for a coordinate request.
		st_lookup, // register bank is searching.
		st_decide, // search result is on the lookup bus.
		st_sprite, // emitter is running a sprite line.
		st_wait1,  // background path, first wait cycle.
		st_wait2   // background path, second wait cycle.
	} print_state_t;

endpackage

/* sprite_regbank.sv */
// Sprite register bank
`timescale 1ns/100ps

module sprite_regbank #(
	parameter int NUM_SPRITES = 8
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     reg_wr,
	input  sprite_pkg::sprite_index_t reg_index,
	input  sprite_pkg::sprite_entry_t reg_entry,
	input  logic                     check_req,
	input  sprite_pkg::coord_t       check_x,
	input  sprite_pkg::coord_t       check_y,
	output sprite_pkg::lookup_t      lookup,
	output logic                     lookup_valid
);
	import sprite_pkg::*;

	sprite_entry_t bank [NUM_SPRITES]; // the sprite registers.
	lookup_t       lookup_next;        // combinational search result.

	// true when c lies on one of the SPRITE_SIZE pixels starting at pos.
	// the sum is one bit wider so sprites near the screen edge do not wrap.
	function automatic logic in_span(input coord_t pos, input coord_t c);
		logic [$bits(coord_t):0] lo;
		logic [$bits(coord_t):0] hi;
		lo = {1'b0, pos};
		hi = lo + ($bits(coord_t) + 1)'(SPRITE_SIZE);
		return ({1'b0, c} >= lo) && ({1'b0, c} < hi);
	endfunction

	////////////////////////////////////////
	// register writes.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < NUM_SPRITES; i++)
				bank[i] <= '0; // every entry starts inactive.
		end else if (reg_wr && (int'(reg_index) < NUM_SPRITES)) begin
			bank[reg_index] <= reg_entry; // seen by lookups from the next cycle.
		end
	end

	////////////////////////////////////////
	// parallel hit search.
	////////////////////////////////////////

	// the loop walks down from the top entry, so the lowest matching
	// index is the last one to write the result and wins.
	always_comb begin
		lookup_next = '0;
		for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
			if (bank[i].active && in_span(bank[i].pos_x, check_x) &&
			    in_span(bank[i].pos_y, check_y)) begin
				lookup_next.hit  = 1'b1;
				lookup_next.base = bank[i].base;
				lookup_next.row  = sprite_offset_t'(check_y - bank[i].pos_y);
				lookup_next.col  = sprite_offset_t'(check_x - bank[i].pos_x);
			end
		end
	end

	// the valid strobe is a one-cycle echo of the request.
	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			lookup_valid <= 1'b0;
		else
			lookup_valid <= check_req;
	end

	// result is held until the next search, a miss leaves hit low.
	always_ff @(posedge clk) begin
		if (check_req)
			lookup <= lookup_next;
	end

endmodule

/* print_control.sv */
// Pixel print state machine
`timescale 1ns/100ps

module print_control (
	input  logic                clk,
	input  logic                reset,
	input  logic                pix_req,
	input  sprite_pkg::coord_t  pix_x,
	input  sprite_pkg::coord_t  pix_y,
	input  sprite_pkg::lookup_t lookup,
	input  logic                lookup_valid,
	input  logic                line_done,
	output logic                check_req,
	output sprite_pkg::coord_t  check_x,
	output sprite_pkg::coord_t  check_y,
	output logic                line_start,
	output sprite_pkg::lookup_t line_info,
	output logic                bg_valid,
	output logic                busy
);
	import sprite_pkg::*;

	print_state_t state;
	print_state_t next_state;
	logic         accept; // request taken in this cycle.

	// a request is only taken while idle and not busy.
	// busy stays high for the cycle of the background strobe, so a
	// request there is dropped like any other request while busy.
	assign accept = (state == st_idle) && pix_req && !busy;

	////////////////////////////////////////
	// next state.
	////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (accept)
					next_state = st_lookup;
			end
			st_lookup: next_state = st_decide; // bank registers its result now.
			st_decide: begin
				if (lookup_valid) begin
					if (lookup.hit)
						next_state = st_sprite; // sprite found under the pixel.
					else
						next_state = st_wait1;  // background pixel.
				end
			end
			st_sprite: begin
				if (line_done)
					next_state = st_idle; // last address of the line is out.
			end
			st_wait1: next_state = st_wait2;
			st_wait2: next_state = st_idle; // background strobe goes out here.
			default:  next_state = st_idle;
		endcase
	end

	////////////////////////////////////////
	// state and strobes.
	////////////////////////////////////////

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state      <= st_idle;
			check_req  <= 1'b0;
			line_start <= 1'b0;
			bg_valid   <= 1'b0;
			busy       <= 1'b0;
		end else begin
			state      <= next_state;
			check_req  <= accept;                               // one-cycle search strobe.
			line_start <= (state == st_decide) && lookup_valid && lookup.hit;
			bg_valid   <= (state == st_wait2);                  // single background strobe.
			case (state)
				st_idle:   busy <= accept; // also clears busy after the background strobe.
				st_sprite: busy <= !line_done;
				default:   busy <= 1'b1;
			endcase
		end
	end

	////////////////////////////////////////
	// coordinate and line payload.
	////////////////////////////////////////

	// the coordinate is latched with the request and held for the bank.
	always_ff @(posedge clk) begin
		if (accept) begin
			check_x <= pix_x;
			check_y <= pix_y;
		end
	end

	// the emitter copies this on line_start.
	always_ff @(posedge clk) begin
		if (state == st_decide && lookup_valid)
			line_info <= lookup;
	end

endmodule

/* sprite_line_emitter.sv */
// Sprite line address emitter
`timescale 1ns/100ps

module sprite_line_emitter (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  line_start,
	input  sprite_pkg::lookup_t   line_info,
	output logic                  mem_valid,
	output sprite_pkg::mem_addr_t mem_addr,
	output logic                  line_done
);
	import sprite_pkg::*;

	logic           active;    // a line is being emitted.
	mem_addr_t      row_base;  // address of column 0 on the current line.
	sprite_offset_t col_cnt;   // column of the address now on the output.
	mem_addr_t      start_row; // row base computed from line_info.
	logic           last_col;  // the current column is the sprite's last one.

	////////////////////////////////////////
	// row base from the lookup result.
	////////////////////////////////////////

	// base plus row times the sprite width, all in memory address width.
	always_comb begin
		start_row = line_info.base + mem_addr_t'(line_info.row) * mem_addr_t'(SPRITE_SIZE);
	end

	assign last_col = (col_cnt == sprite_offset_t'(SPRITE_SIZE - 1));

	////////////////////////////////////////
	// column counter.
	////////////////////////////////////////

	// the first address appears the cycle after line_start and one more
	// follows every cycle until the last column has been shown.
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			active <= 1'b0;
		end else if (line_start) begin
			active <= 1'b1;
		end else if (active && last_col) begin
			active <= 1'b0; // line finished.
		end
	end

	always_ff @(posedge clk) begin
		if (line_start) begin
			row_base <= start_row;
			col_cnt  <= line_info.col; // the run starts at the hit column.
		end else if (active && !last_col) begin
			col_cnt <= col_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// outputs.
	////////////////////////////////////////

	assign mem_valid = active;
	assign line_done = active && last_col; // marks the final address of the line.

	// idle cycles put zero on the address lines.
	always_comb begin
		if (active)
			mem_addr = row_base + mem_addr_t'(col_cnt);
		else
			mem_addr = '0;
	end

endmodule

/* sprite_printer_top.sv */
// Sprite printer top level
`timescale 1ns/100ps

module sprite_printer_top #(
	parameter int NUM_SPRITES = 8
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      reg_wr,
	input  sprite_pkg::sprite_index_t reg_index,
	input  sprite_pkg::sprite_entry_t reg_entry,
	input  logic                      pix_req,
	input  sprite_pkg::coord_t        pix_x,
	input  sprite_pkg::coord_t        pix_y,
	output logic                      mem_valid,
	output sprite_pkg::mem_addr_t     mem_addr,
	output logic                      sprite_on,
	output logic                      busy
);
	import sprite_pkg::*;

	logic      check_req;    // search strobe to the bank.
	coord_t    check_x;
	coord_t    check_y;
	lookup_t   lookup;       // search result.
	logic      lookup_valid;
	logic      line_start;   // starts the emitter.
	lookup_t   line_info;
	logic      line_done;    // emitter is on its last address.
	logic      bg_valid;     // background strobe from the FSM.
	logic      emit_valid;
	mem_addr_t emit_addr;

	sprite_regbank #(
		.NUM_SPRITES (NUM_SPRITES)
	) u_sprite_regbank (
		.clk, .reset,
		.reg_wr, .reg_index, .reg_entry,
		.check_req, .check_x, .check_y,
		.lookup, .lookup_valid
	);

	print_control u_print_control (
		.clk, .reset,
		.pix_req, .pix_x, .pix_y,
		.lookup, .lookup_valid, .line_done,
		.check_req, .check_x, .check_y,
		.line_start, .line_info, .bg_valid, .busy
	);

	sprite_line_emitter u_sprite_line_emitter (
		.clk, .reset,
		.line_start, .line_info,
		.mem_valid (emit_valid),
		.mem_addr  (emit_addr),
		.line_done
	);

	////////////////////////////////////////
	// output merge.
	////////////////////////////////////////

	// the two sources never strobe in the same cycle.
	assign mem_valid = emit_valid | bg_valid;
	assign mem_addr  = bg_valid ? BG_ADDR : emit_addr; // emitter gives zero when idle.
	assign sprite_on = emit_valid;

endmodule

/* sprite_checker.sv */
// Sprite printer output checker
`timescale 1ns/100ps

module sprite_checker (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  pix_req,
	input  logic                  busy,
	input  logic                  mem_valid,
	input  sprite_pkg::mem_addr_t mem_addr,
	input  logic                  sprite_on,
	output int                    mismatches,
	output int                    failures,
	output logic                  idle
);
	import sprite_pkg::*;

	// cycles from the request edge to the first strobe of each kind.
	localparam int SPRITE_LATENCY = 3;
	localparam int BG_LATENCY     = 4;

	typedef struct packed {
		logic       sprite;     // run is expected with sprite_on high.
		logic [7:0] count;      // zero leaves the run length open.
		mem_addr_t  first;
		logic       check_addr;
	} run_t;

	typedef enum logic [1:0] {chk_idle, chk_wait, chk_run} phase_t;

	run_t      pending [$]; // runs for requests not yet accepted.
	run_t      cur;
	phase_t    phase = chk_idle;
	int        cycles;      // edges since the request was accepted.
	int        seen;        // strobes of the current run so far.
	mem_addr_t next_addr;
	int        mismatch_count = 0;
	int        failure_count = 0;

	assign mismatches = mismatch_count;
	assign failures   = failure_count;

	task automatic expect_run(input logic sprite, input int count, input mem_addr_t first,
	                          input logic check_addr);
		run_t r;
		r.sprite     = sprite;
		r.count      = 8'(count);
		r.first      = first;
		r.check_addr = check_addr;
		pending.push_back(r);
	endtask

	// one strobe of the current run.
	task automatic check_strobe;
		if (sprite_on !== cur.sprite) begin
			mismatch_count++;
			$display("mismatch at %0t: sprite_on is %b, expected %b", $time, sprite_on, cur.sprite);
		end
		if (cur.check_addr && mem_addr !== next_addr) begin
			mismatch_count++;
			$display("mismatch at %0t: mem_addr is %0d, expected %0d", $time, mem_addr, next_addr);
		end
		next_addr = next_addr + 1'b1; // addresses of a line rise by one.
		seen++;
	endtask

	// busy is high from the cycle after the request up to the last strobe.
	task automatic check_busy(input logic expected);
		if (busy !== expected) begin
			mismatch_count++;
			$display("mismatch at %0t: busy is %b, expected %b", $time, busy, expected);
		end
	endtask

	// the strobe that follows the request by n cycles is sampled n + 1 edges later.
	always @(posedge clk) begin
		if (reset) begin
			case (phase)
				chk_idle: begin
					check_busy(1'b0);
					if (mem_valid) begin
						failure_count++;
						$display("error at %0t: address strobe with no request outstanding", $time);
					end
				end
				chk_wait: begin
					cycles++;
					check_busy(1'b1);
					if (mem_valid) begin
						if (cycles != (cur.sprite ? SPRITE_LATENCY : BG_LATENCY) + 1) begin
							mismatch_count++;
							$display("mismatch at %0t: first address %0d cycles after the request",
							         $time, cycles - 1);
						end
						check_strobe();
						phase = chk_run;
					end else if (cycles > BG_LATENCY + 1) begin
						failure_count++;
						$display("error at %0t: no address came for the request", $time);
						phase = chk_idle;
					end
				end
				chk_run: begin
					check_busy(mem_valid);
					if (mem_valid) begin
						check_strobe();
					end else begin
						if (cur.count != 0) begin
							failure_count++;
							$display("error at %0t: line stopped after %0d of %0d addresses",
							         $time, seen, cur.count);
						end
						phase = chk_idle;
					end
				end
				default: phase = chk_idle;
			endcase
			if (phase == chk_run && cur.count != 0 && seen == cur.count)
				phase = chk_idle; // the run is complete.
			// a request counts as taken only when no run is outstanding.
			if (pix_req && phase == chk_idle) begin
				if (pending.size() == 0) begin
					failure_count++;
					$display("error at %0t: request accepted with no expected run", $time);
				end else begin
					cur       = pending.pop_front();
					phase     = chk_wait;
					cycles    = 0;
					seen      = 0;
					next_addr = cur.first;
				end
			end
		end
		idle = (phase == chk_idle) && (pending.size() == 0);
	end

endmodule

/* tb_sprite_printer.sv */
// Sprite printer testbench
`timescale 1ns/100ps

module tb_sprite_printer;
	import sprite_pkg::*;

	localparam int NUM_SPRITES    = 8;
	localparam int CLK_PERIOD     = 40; // ns.
	localparam int RESET_CYCLES   = 16;
	localparam int DRIVE_DELAY    = 2;  // inputs change this long after the rising edge.
	localparam int REQUEST_CYCLES = 40; // watchdog allowance for each coordinate request.
	localparam mem_addr_t BACKGROUND_ADDR = 14'd16383;

	logic          clk;
	logic          reset;
	logic          reg_wr;
	sprite_index_t reg_index;
	sprite_entry_t reg_entry;
	logic          pix_req;
	coord_t        pix_x;
	coord_t        pix_y;
	logic          mem_valid;
	mem_addr_t     mem_addr;
	logic          sprite_on;
	logic          busy;

	int         mismatches;   // wrong values seen by the checker.
	int         failures;     // missing or extra strobes seen by the checker.
	logic       checker_idle; // no run outstanding in the checker.
	int         stim_errors = 0;
	int         num_requests = 0;
	bit         counted = 1'b0; // request count is known, watchdog may start.
	int         fd;
	logic [7:0] kind;           // record letter, zero at the end of the file.
	int         val [5];        // numeric fields of the current record.

	sprite_printer_top #(
		.NUM_SPRITES (NUM_SPRITES)
	) u_sprite_printer_top (
		.clk, .reset,
		.reg_wr, .reg_index, .reg_entry,
		.pix_req, .pix_x, .pix_y,
		.mem_valid, .mem_addr, .sprite_on, .busy
	);

	sprite_checker u_checker (
		.clk, .reset,
		.pix_req, .busy,
		.mem_valid, .mem_addr, .sprite_on,
		.mismatches, .failures,
		.idle (checker_idle)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// stimulus file and drive tasks.
	////////////////////////////////////////

	// reads the next record and skips comment lines that open with a lone #.
	task automatic read_record;
		int            n;
		logic [63:0]   word;
		logic [1023:0] rest;
		bit            found;
		found = 1'b0;
		kind  = 8'd0;
		while (!found) begin
			word = '0;
			n = $fscanf(fd, "%s", word);
			if (n != 1) begin
				found = 1'b1; // end of the file.
			end else if (word == "#") begin
				n = $fgets(rest, fd);
			end else if (word == "W" || word == "R") begin
				n = $fscanf(fd, "%d %d %d %d %d", val[0], val[1], val[2], val[3], val[4]);
				kind  = word[7:0];
				found = 1'b1;
			end else if (word == "H") begin
				n = $fscanf(fd, "%d %d %d", val[0], val[1], val[2]);
				kind  = word[7:0];
				found = 1'b1;
			end else begin
				$display("error: the stimulus file holds an unknown record kind");
				stim_errors++;
				n = $fgets(rest, fd);
			end
		end
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic wait_idle;
		while (busy)
			next_cycle();
	endtask

	task automatic write_entry(input int index, input int active, input int x, input int y,
	                           input int base);
		reg_wr           = 1'b1;
		reg_index        = sprite_index_t'(index);
		reg_entry.active = (active != 0);
		reg_entry.pos_x  = coord_t'(x);
		reg_entry.pos_y  = coord_t'(y);
		reg_entry.base   = mem_addr_t'(base);
		next_cycle();
		reg_wr = 1'b0;
	endtask

	// with drop set, two more pulses arrive while busy: one during the
	// lookup and one while the line is being emitted.
	task automatic send_request(input coord_t x, input coord_t y, input bit drop);
		wait_idle();
		pix_req = 1'b1;
		pix_x   = x;
		pix_y   = y;
		next_cycle();
		if (drop) begin
			pix_x = x + 1'b1; // held high, so it is sampled again while busy.
			next_cycle();
			pix_req = 1'b0;
			repeat (3) next_cycle();
			pix_req = 1'b1;
			pix_y   = y + 1'b1;
			next_cycle();
		end
		pix_req = 1'b0;
	endtask

	task automatic count_requests;
		read_record();
		while (kind != 8'd0) begin
			if (kind == "R" || kind == "H")
				num_requests++;
			read_record();
		end
		$fclose(fd);
	endtask

	task automatic apply_records;
		read_record();
		while (kind != 8'd0) begin
			case (kind)
				"W": write_entry(val[0], val[1], val[2], val[3], val[4]);
				"R": begin
					u_checker.expect_run(1'b1, val[2], mem_addr_t'(val[3]), 1'b1);
					send_request(coord_t'(val[0]), coord_t'(val[1]), val[4] != 0);
				end
				"H": begin
					if (val[2] != 0)
						u_checker.expect_run(1'b1, 0, '0, 1'b0); // any sprite run.
					else
						u_checker.expect_run(1'b0, 1, BACKGROUND_ADDR, 1'b1);
					send_request(coord_t'(val[0]), coord_t'(val[1]), 1'b0);
				end
				default: ;
			endcase
			read_record();
		end
	endtask

	////////////////////////////////////////
	// main sequence and watchdog.
	////////////////////////////////////////

	initial begin : stimulus
		reset     = 1'b0;
		reg_wr    = 1'b0;
		reg_index = '0;
		reg_entry = '0;
		pix_req   = 1'b0;
		pix_x     = '0;
		pix_y     = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b1;
		fd = $fopen("sprite_stimulus.txt", "r");
		if (fd == 0) begin
			$display("error: cannot open the stimulus file sprite_stimulus.txt");
			stim_errors++;
		end else begin
			count_requests();
			counted = 1'b1;
			fd = $fopen("sprite_stimulus.txt", "r");
			apply_records();
			$fclose(fd);
			wait_idle();
			repeat (8) next_cycle(); // lets the checker see the last strobes.
			if (!checker_idle) begin
				$display("error: an expected address run never appeared");
				stim_errors++;
			end
		end
		$display("error counts: %0d mismatches, %0d other failures", mismatches,
		         failures + stim_errors);
		if (mismatches == 0 && failures + stim_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin : watchdog
		wait (counted);
		#((num_requests * REQUEST_CYCLES + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: the test did not finish in the time allowed for %0d requests",
		         num_requests);
		$display("Done: errors found");
		$finish;
	end

endmodule

/* sprite_stimulus.txt */
# W index active pos_x pos_y base | R x y count first_addr drop | H x y hit
# all fields decimal, R and H are coordinate requests with their expected result
W 0 1 100 50 0
W 1 1 110 60 400
W 5 1 300 200 1000
W 7 1 1010 470 2000
H 10 10 0
H 640 479 0
R 300 200 20 1000 0
R 319 219 1 1399 0
H 320 219 0
H 319 220 0
H 299 200 0
R 305 207 15 1145 0
H 315 205 1
R 112 63 8 272 0
R 125 75 5 715 0
R 310 210 10 1210 1
W 0 0 100 50 0
R 112 63 18 462 0
H 105 55 0
W 1 0 110 60 400
H 112 63 0
W 3 1 100 50 3000
R 100 50 20 3000 0
W 2 1 95 45 5000
R 100 50 15 5105 0
R 1023 470 7 2013 0
R 1023 489 7 2393 0
H 5 470 0

/* compile.f */
sprite_pkg.sv
sprite_regbank.sv
print_control.sv
sprite_line_emitter.sv
sprite_printer_top.sv
sprite_checker.sv
tb_sprite_printer.sv

/* Bender.yml */
package:
  name: sprite_printer

sources:
  - files:
      - sprite_pkg.sv
      - sprite_regbank.sv
      - print_control.sv
      - sprite_line_emitter.sv
      - sprite_printer_top.sv
  - target: test
    files:
      - sprite_checker.sv
      - tb_sprite_printer.sv
